// ==== include/chess_settings.svh ====
//**********************************************************************
// core count, core index width, command opcodes and reset values
//**********************************************************************
`ifndef CHESS_SETTINGS_SVH
`define CHESS_SETTINGS_SVH

// number of chess cores on the command stream
`define CHESS_NUM_CORES 8

// width of a core index
`define CHESS_CORE_IDX_W 3

// search register reset values
`define CHESS_SM_RESET 3'd0
`define CHESS_MM_RESET 2'd0

// SET-CORE prefix, low 3 bits carry the core index
`define CHESS_OP_SET_CORE 5'b00011

// command class in the top two bits
`define CHESS_OP_WRITE 2'b00
`define CHESS_OP_READ  2'b01
`define CHESS_OP_SS1   2'b10
`define CHESS_OP_SS2   2'b11

`endif

// ==== design/chess_pkg.sv ====
//**********************************************************************
// vector typedefs and the reply state encoding
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

package chess_pkg;

    // command or reply byte
    typedef logic [7:0] cmd_byte_t;

    // board square index
    typedef logic [5:0] square_t;

    typedef logic [2:0] state_mode_t;  // search state mode
    typedef logic [1:0] mask_mode_t;   // move mask mode
    typedef logic [3:0] write_bus_t;   // board write bus select

    // index of one core
    typedef logic [`CHESS_CORE_IDX_W-1:0] core_idx_t;

    // responder states
    typedef enum logic [0:0] {
        REPLY_IDLE = 1'b0,
        REPLY_WAIT = 1'b1  // read held until tx_ready
    } reply_state_t;

endpackage

`default_nettype wire

// ==== design/chess_reply.sv ====
//**********************************************************************
// read-command responder with wait-for-ready state
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

module chess_reply (
    input  wire                      clk60,
    input  wire                      gateware_reset,
    input  wire                      rx_next_i,
    input  wire chess_pkg::cmd_byte_t   rx_data_i,
    input  wire                      tx_ready_i,
    input  wire                      wtm_i,
    input  wire chess_pkg::square_t     ss1_i,
    input  wire                      ss1_valid_i,
    input  wire chess_pkg::square_t     ss2_i,
    input  wire                      ss2_valid_i,
    input  wire chess_pkg::mask_mode_t  mask_mode_i,
    input  wire chess_pkg::state_mode_t state_mode_i,
    input  wire chess_pkg::write_bus_t  write_bus_i,
    output chess_pkg::cmd_byte_t        tx_data_o,
    output logic                     tx_valid_o,
    output logic                     busy_o
);

    chess_pkg::reply_state_t state;
    logic [5:0]              stored_cmd;  // reply select of the held read
    chess_pkg::cmd_byte_t    reply;
    logic [5:0]              reply_sel;
    logic                    rd_cmd;

    assign busy_o = (state == chess_pkg::REPLY_WAIT);
    assign rd_cmd = rx_next_i && (rx_data_i[7:6] == `CHESS_OP_READ);

    // in WAIT the held command picks the reply
    assign reply_sel = busy_o ? stored_cmd : rx_data_i[5:0];

    always_comb begin
        casez (reply_sel)
            6'b00000?: reply = chess_pkg::cmd_byte_t'({7'b0, wtm_i});
            6'b000100: reply = {1'b0, ss1_valid_i, ss1_i};
            6'b000101: reply = {1'b0, ss2_valid_i, ss2_i};
            6'b001???: reply = chess_pkg::cmd_byte_t'({6'b0, mask_mode_i});
            6'b01????: reply = chess_pkg::cmd_byte_t'({5'b0, state_mode_i});
            6'b1?????: reply = chess_pkg::cmd_byte_t'({4'b0, write_bus_i});
            default:   reply = '0;  // unused read codes
        endcase
    end

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset) begin
            state      <= chess_pkg::REPLY_IDLE;
            tx_valid_o <= 1'b0;
            tx_data_o  <= '0;
        end else begin
            tx_valid_o <= 1'b0;  // one-cycle pulse
            tx_data_o  <= '0;
            case (state)
                chess_pkg::REPLY_IDLE: begin
                    if (rd_cmd && tx_ready_i) begin
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= reply;
                    end else if (rd_cmd) begin
                        state <= chess_pkg::REPLY_WAIT;
                    end
                end
                chess_pkg::REPLY_WAIT: begin
                    if (tx_ready_i) begin
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= reply;
                        state      <= chess_pkg::REPLY_IDLE;
                    end
                end
                default: state <= chess_pkg::REPLY_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk60) begin
        if (rd_cmd && !tx_ready_i && !busy_o)
            stored_cmd <= rx_data_i[5:0];
    end

endmodule

`default_nettype wire

// ==== design/chess_core.sv ====
//**********************************************************************
// per-core search register file, write decode and read responder
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

module chess_core (
    input  wire                       clk60,
    input  wire                       gateware_reset,
    input  wire                       rx_next_i,
    input  wire chess_pkg::cmd_byte_t rx_data_i,
    input  wire                       tx_ready_i,
    output wire                       tx_valid_o,
    output wire chess_pkg::cmd_byte_t tx_data_o
);

    logic                   wtm;
    chess_pkg::square_t     ss1;
    logic                   ss1_valid;
    chess_pkg::square_t     ss2;
    logic                   ss2_valid;
    chess_pkg::mask_mode_t  mask_mode;
    chess_pkg::state_mode_t state_mode;
    chess_pkg::write_bus_t  write_bus;

    logic busy;
    logic wr_en;

    // writes are dropped while a reply is held back
    assign wr_en = rx_next_i && !busy;

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset) begin
            wtm        <= 1'b0;
            ss1        <= '0;
            ss1_valid  <= 1'b0;
            ss2        <= '0;
            ss2_valid  <= 1'b0;
            mask_mode  <= `CHESS_MM_RESET;
            state_mode <= `CHESS_SM_RESET;
            write_bus  <= '0;
        end else if (wr_en) begin
            case (rx_data_i[7:6])
                `CHESS_OP_WRITE: begin
                    casez (rx_data_i[5:0])
                        6'b00000?: wtm        <= rx_data_i[0];
                        6'b00010?: ss1_valid  <= rx_data_i[0];
                        6'b00011?: ss2_valid  <= rx_data_i[0];
                        6'b0010??: mask_mode  <= rx_data_i[1:0];
                        6'b010???: state_mode <= rx_data_i[2:0];
                        6'b10????: write_bus  <= rx_data_i[3:0];
                        default: ;  // SET-CORE and unused codes
                    endcase
                end
                `CHESS_OP_SS1: ss1 <= rx_data_i[5:0];
                `CHESS_OP_SS2: ss2 <= rx_data_i[5:0];
                default: ;  // reads go to the responder
            endcase
        end
    end

    chess_reply u_reply (
        .clk60          (clk60),
        .gateware_reset (gateware_reset),
        .rx_next_i      (rx_next_i),
        .rx_data_i      (rx_data_i),
        .tx_ready_i     (tx_ready_i),
        .wtm_i          (wtm),
        .ss1_i          (ss1),
        .ss1_valid_i    (ss1_valid),
        .ss2_i          (ss2),
        .ss2_valid_i    (ss2_valid),
        .mask_mode_i    (mask_mode),
        .state_mode_i   (state_mode),
        .write_bus_i    (write_bus),
        .tx_data_o      (tx_data_o),
        .tx_valid_o     (tx_valid_o),
        .busy_o         (busy)
    );

endmodule

`default_nettype wire

// ==== design/core_select.sv ====
//**********************************************************************
// selected-core register, SET-CORE decode and transmit mux
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

module core_select (
    input  wire                       clk60,
    input  wire                       gateware_reset,
    input  wire                       rx_next_i,
    input  wire chess_pkg::cmd_byte_t rx_data_i,
    input  wire [`CHESS_NUM_CORES-1:0] core_tx_valid_i,
    input  wire chess_pkg::cmd_byte_t [`CHESS_NUM_CORES-1:0] core_tx_data_i,
    output logic                      tx_valid_o,
    output chess_pkg::cmd_byte_t      tx_data_o
);

    chess_pkg::core_idx_t sel_core;
    logic                 set_core;

    assign set_core = rx_next_i && (rx_data_i[7:3] == `CHESS_OP_SET_CORE);

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset)
            sel_core <= '0;  // core 0 after reset
        else if (set_core)
            sel_core <= rx_data_i[`CHESS_CORE_IDX_W-1:0];
    end

    // only the selected core reaches the host
    assign tx_valid_o = core_tx_valid_i[sel_core];
    assign tx_data_o  = core_tx_data_i[sel_core];

endmodule

`default_nettype wire

// ==== design/chess_cmd_top.sv ====
//**********************************************************************
// command path top with the core array and the core selector
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

module chess_cmd_top (
    input  wire                       clk60,
    input  wire                       gateware_reset,
    input  wire                       rx_next_i,
    input  wire chess_pkg::cmd_byte_t rx_data_i,
    input  wire                       tx_ready_i,
    output wire                       tx_valid_o,
    output wire chess_pkg::cmd_byte_t tx_data_o
);

    wire [`CHESS_NUM_CORES-1:0]                       core_tx_valid;
    wire chess_pkg::cmd_byte_t [`CHESS_NUM_CORES-1:0] core_tx_data;

    // every core sees the same receive stream
    genvar i;
    generate
        for (i = 0; i < `CHESS_NUM_CORES; i++) begin : gen_core
            chess_core u_core (
                .clk60          (clk60),
                .gateware_reset (gateware_reset),
                .rx_next_i      (rx_next_i),
                .rx_data_i      (rx_data_i),
                .tx_ready_i     (tx_ready_i),
                .tx_valid_o     (core_tx_valid[i]),
                .tx_data_o      (core_tx_data[i])
            );
        end
    endgenerate

    core_select u_select (
        .clk60           (clk60),
        .gateware_reset  (gateware_reset),
        .rx_next_i       (rx_next_i),
        .rx_data_i       (rx_data_i),
        .core_tx_valid_i (core_tx_valid),
        .core_tx_data_i  (core_tx_data),
        .tx_valid_o      (tx_valid_o),
        .tx_data_o       (tx_data_o)
    );

endmodule

`default_nettype wire

// ==== test/chess_cmd_chk.sv ====
//**********************************************************************
// concurrent assertions on the transmit port, bound to the top level
//**********************************************************************
`default_nettype none

module chess_cmd_chk (
    input wire                       clk60,
    input wire                       gateware_reset,
    input wire                       tx_valid_i,
    input wire chess_pkg::cmd_byte_t tx_data_i
);

    int fail_count = 0;  // assertion failures so far

    // a reply is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk60) disable iff (gateware_reset)
        tx_valid_i |=> !tx_valid_i)
    else begin
        fail_count++;
        $error("tx_valid_o high on two consecutive cycles");
    end

    a_quiet_in_reset: assert property (@(posedge clk60)
        gateware_reset |-> !tx_valid_i)
    else begin
        fail_count++;
        $error("tx_valid_o high during reset");
    end

    // idle data is zero
    a_zero_data: assert property (@(posedge clk60)
        !tx_valid_i |-> (tx_data_i == 8'h00))
    else begin
        fail_count++;
        $error("tx_data_o not zero while tx_valid_o is low");
    end

endmodule

bind chess_cmd_top chess_cmd_chk u_chk (
    .clk60          (clk60),
    .gateware_reset (gateware_reset),
    .tx_valid_i     (tx_valid_o),
    .tx_data_i      (tx_data_o)
);

`default_nettype wire

// ==== test/chess_cmd_tb.sv ====
//**********************************************************************
// directed-test testbench with clock, reset, stimulus and compare tasks
//**********************************************************************
`default_nettype none

`include "chess_settings.svh"

module chess_cmd_tb;

    localparam int REPLY_TIMEOUT = 16;  // cycles

    logic                 clk60;
    logic                 gateware_reset;
    logic                 rx_next;
    chess_pkg::cmd_byte_t rx_data;
    logic                 tx_ready;
    wire                  tx_valid;
    wire chess_pkg::cmd_byte_t tx_data;

    logic [31:0] lfsr_state;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int failed_tests = 0;

    // reference copy of the search registers
    logic                   m_wtm;
    chess_pkg::square_t     m_ss1;
    logic                   m_ss1_valid;
    chess_pkg::square_t     m_ss2;
    logic                   m_ss2_valid;
    chess_pkg::mask_mode_t  m_mask;
    chess_pkg::state_mode_t m_state;
    chess_pkg::write_bus_t  m_wbus;

    chess_cmd_top u_dut (
        .clk60          (clk60),
        .gateware_reset (gateware_reset),
        .rx_next_i      (rx_next),
        .rx_data_i      (rx_data),
        .tx_ready_i     (tx_ready),
        .tx_valid_o     (tx_valid),
        .tx_data_o      (tx_data)
    );

    initial begin
        clk60 = 1'b0;
        forever #5 clk60 = ~clk60;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
        return value;
    endfunction

    task automatic reset_model();
        m_wtm       = 1'b0;
        m_ss1       = '0;
        m_ss1_valid = 1'b0;
        m_ss2       = '0;
        m_ss2_valid = 1'b0;
        m_mask      = `CHESS_MM_RESET;
        m_state     = `CHESS_SM_RESET;
        m_wbus      = '0;
    endtask

    task automatic apply_to_model(input chess_pkg::cmd_byte_t cmd);
        casez (cmd)
            8'b0000000?: m_wtm       = cmd[0];
            8'b0000010?: m_ss1_valid = cmd[0];
            8'b0000011?: m_ss2_valid = cmd[0];
            8'b000010??: m_mask      = cmd[1:0];
            8'b00010???: m_state     = cmd[2:0];
            8'b0010????: m_wbus      = cmd[3:0];
            8'b10??????: m_ss1       = cmd[5:0];
            8'b11??????: m_ss2       = cmd[5:0];
            default: ;  // set-core, reads, undefined writes
        endcase
    endtask

    // reply table of the read commands
    function automatic chess_pkg::cmd_byte_t expected_reply(input chess_pkg::cmd_byte_t code);
        chess_pkg::cmd_byte_t r;
        casez (code[5:0])
            6'b00000?: r = {7'b0, m_wtm};
            6'b000100: r = {1'b0, m_ss1_valid, m_ss1};
            6'b000101: r = {1'b0, m_ss2_valid, m_ss2};
            6'b001???: r = {6'b0, m_mask};
            6'b01????: r = {5'b0, m_state};
            6'b1?????: r = {4'b0, m_wbus};
            default:   r = 8'h00;
        endcase
        return r;
    endfunction

    function automatic string field_name(input int field);
        case (field)
            0: return "wtm";
            1: return "ss1";
            2: return "ss2";
            3: return "mask_mode";
            4: return "state_mode";
            default: return "write_bus";
        endcase
    endfunction

    // don't-care bits of the read codes are random
    function automatic chess_pkg::cmd_byte_t read_code(input int field);
        case (field)
            0: return {2'b01, 5'b00000, 1'(draw_bits(1))};
            1: return 8'h44;
            2: return 8'h45;
            3: return {2'b01, 3'b001, 3'(draw_bits(3))};
            4: return {2'b01, 2'b01, 4'(draw_bits(4))};
            default: return {2'b01, 1'b1, 5'(draw_bits(5))};
        endcase
    endfunction

    function automatic chess_pkg::cmd_byte_t write_code(input int kind);
        case (kind)
            0: return {7'b0000000, 1'(draw_bits(1))};
            1: return {7'b0000010, 1'(draw_bits(1))};
            2: return {7'b0000011, 1'(draw_bits(1))};
            3: return {6'b000010, 2'(draw_bits(2))};
            4: return {5'b00010, 3'(draw_bits(3))};
            5: return {4'b0010, 4'(draw_bits(4))};
            6: return {2'b10, 6'(draw_bits(6))};
            default: return {2'b11, 6'(draw_bits(6))};
        endcase
    endfunction

    // writes that would change a register if they were taken
    function automatic chess_pkg::cmd_byte_t blocked_write(input int idx);
        case (idx % 5)
            0: return {7'b0000000, ~m_wtm};
            1: return {2'b10, ~m_ss1};
            2: return {4'b0010, ~m_wbus};
            3: return {5'b00010, ~m_state};
            default: return {6'b000010, ~m_mask};
        endcase
    endfunction

    task automatic compare_byte(input string sig, input string ctx,
                                input chess_pkg::cmd_byte_t got, input chess_pkg::cmd_byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s (%s): got 0x%02h, expected 0x%02h", sig, ctx, got, exp);
        end
    endtask

    task automatic compare_bit(input string sig, input string ctx, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s (%s): got 0x%0h, expected 0x%0h", sig, ctx, got, exp);
        end
    endtask

    task automatic compare_count(input string sig, input string ctx, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("MISMATCH %s (%s): got 0x%0h, expected 0x%0h", sig, ctx, got, exp);
        end
    endtask

    // one strobe cycle, ends on the following falling edge
    task automatic send_byte(input chess_pkg::cmd_byte_t cmd);
        rx_next = 1'b1;
        rx_data = cmd;
        @(negedge clk60);
        rx_next = 1'b0;
        rx_data = 8'h00;
    endtask

    task automatic write_and_track(input chess_pkg::cmd_byte_t cmd);
        send_byte(cmd);
        apply_to_model(cmd);
    endtask

    // latency counts from the edge before the current falling edge
    task automatic wait_reply(input string what, output chess_pkg::cmd_byte_t data,
                              output int latency);
        int cycles;
        cycles  = 1;
        data    = 8'h00;
        latency = -1;
        while (cycles <= REPLY_TIMEOUT && latency < 0) begin
            if (tx_valid) begin
                latency = cycles;
                data    = tx_data;
            end else begin
                @(negedge clk60);
                cycles++;
            end
        end
        if (latency < 0) begin
            error_count++;
            $display("ERROR: no reply on tx_valid_o within %0d cycles for %s",
                     REPLY_TIMEOUT, what);
        end
    endtask

    task automatic read_and_check(input chess_pkg::cmd_byte_t code, input string what);
        chess_pkg::cmd_byte_t exp;
        chess_pkg::cmd_byte_t got;
        int latency;
        exp = expected_reply(code);
        send_byte(code);
        wait_reply(what, got, latency);
        if (latency > 0) begin
            compare_byte("tx_data_o", what, got, exp);
            compare_count("tx_valid_o latency", what, latency, 1);
        end
        @(negedge clk60);  // past the pulse
    endtask

    task automatic check_quiet(input int cycles, input string ctx);
        int i;
        for (i = 0; i < cycles; i++) begin
            compare_bit("tx_valid_o", ctx, tx_valid, 1'b0);
            @(negedge clk60);
        end
    endtask

    task automatic check_all_regs();
        int field;
        for (field = 0; field < 6; field++)
            read_and_check(read_code(field), field_name(field));
    endtask

    task automatic test_reset_defaults();
        check_quiet(3, "after reset");
        check_all_regs();
    endtask

    task automatic test_write_read();
        int round;
        int kind;
        int field;
        for (round = 0; round < 4; round++) begin
            for (kind = 0; kind < 8; kind++) begin
                field = (kind < 6) ? kind : kind - 5;  // ss1/ss2 payloads
                write_and_track(write_code(kind));
                read_and_check(read_code(field), field_name(field));
            end
        end
    endtask

    task automatic test_back_pressure();
        chess_pkg::cmd_byte_t code;
        chess_pkg::cmd_byte_t exp;
        chess_pkg::cmd_byte_t got;
        int round;
        int stall;
        int latency;
        int i;
        for (round = 0; round < 3; round++) begin
            code  = read_code((4 * round + 1) % 6);
            exp   = expected_reply(code);
            stall = 1 + int'(draw_bits(3));
            tx_ready = 1'b0;
            send_byte(code);
            for (i = 0; i < stall; i++) begin
                compare_bit("tx_valid_o", "held read", tx_valid, 1'b0);
                send_byte(blocked_write(i));  // must be dropped
            end
            tx_ready = 1'b1;
            @(negedge clk60);
            wait_reply("held read", got, latency);
            if (latency > 0) begin
                compare_byte("tx_data_o", "held read", got, exp);
                compare_count("tx_valid_o latency", "held read", latency, 1);
            end
            @(negedge clk60);
            check_quiet(4, "after held reply");
            check_all_regs();
        end
    endtask

    task automatic test_broadcast_select();
        chess_pkg::core_idx_t core;
        int kind;
        for (kind = 0; kind < 8; kind++)
            write_and_track(write_code(kind));
        core = chess_pkg::core_idx_t'(draw_bits(`CHESS_CORE_IDX_W));
        write_and_track({`CHESS_OP_SET_CORE, core});
        check_quiet(2, "after set-core");
        check_all_regs();
        write_and_track({`CHESS_OP_SET_CORE, 3'd7});
        check_all_regs();
        write_and_track({`CHESS_OP_SET_CORE, 3'd0});
    endtask

    task automatic test_undefined();
        read_and_check(8'h46, "undefined read 0x46");
        read_and_check(8'h47, "former status read 0x47");
        read_and_check(8'h42, "undefined read 0x42");
        read_and_check(8'h43, "undefined read 0x43");
        check_quiet(3, "after undefined reads");
        write_and_track(8'h02);
        write_and_track(8'h03);
        write_and_track({4'b0011, 4'(draw_bits(4))});
        check_quiet(2, "after undefined writes");
        check_all_regs();
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    initial begin
        int start;
        int assert_fails;
        gateware_reset = 1'b1;
        rx_next        = 1'b0;
        rx_data        = 8'h00;
        tx_ready       = 1'b1;
        lfsr_state     = 32'hadc6_9a19;
        reset_model();
        repeat (5) @(posedge clk60);
        @(negedge clk60);
        gateware_reset = 1'b0;

        start = error_count;
        test_reset_defaults();
        finish_test("reset_defaults", start);
        start = error_count;
        test_write_read();
        finish_test("write_read", start);
        start = error_count;
        test_back_pressure();
        finish_test("back_pressure", start);
        start = error_count;
        test_broadcast_select();
        finish_test("broadcast_select", start);
        start = error_count;
        test_undefined();
        finish_test("undefined_commands", start);

        assert_fails = u_dut.u_chk.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, failed_tests, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== chess_cmd_top.f ====
+incdir+include
design/chess_pkg.sv
design/chess_reply.sv
design/chess_core.sv
design/core_select.sv
design/chess_cmd_top.sv
test/chess_cmd_chk.sv
test/chess_cmd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the command path testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module chess_cmd_tb -f chess_cmd_top.f; then
    echo "verilator build failed"
    exit 1
fi

# a failed assertion must not stop the run before the summary
sim_out=$(./obj_dir/Vchess_cmd_tb +verilator+error+limit+1000 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation finished: PASS" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
